// File: sim.f
+incdir+.
oq_data_pkg.sv
oq_cmd_pkg.sv
oq_operand_intake.sv
oq_data_fifo.sv
oq_operand_formatter.sv
operand_queue_top.sv
tb_operand_queue.sv

// File: Makefile
# Verilator build and run of the operand queue testbench

VERILATOR ?= verilator
TOP       ?= tb_operand_queue
RTL_TOP   ?= operand_queue_top
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
FAIL_MSG  ?= tests failed
PASS_MSG  ?= all tests passed
RTL_SRCS  ?= oq_data_pkg.sv oq_cmd_pkg.sv oq_operand_intake.sv oq_data_fifo.sv \
             oq_operand_formatter.sv operand_queue_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi

lint:
	$(VERILATOR) --lint-only -Wall +incdir+. --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_operand_queue.sv
//////////////////////////////
// Operand queue testbench
// Requester model, reference formatter and output checks
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "oq_cfg.svh"

module tb_operand_queue import oq_data_pkg::*; import oq_cmd_pkg::*; ();

  localparam int CLK_PERIOD  = 100;
  // Sum of nwords over all commands sent below
  localparam int TOTAL_WORDS = 63;

  logic    clk_i;
  logic    rst_n_i;
  elen_t   operand_i;
  logic    operand_valid_i;
  logic    operand_issued_i;
  logic    operand_queue_ready_o;
  oq_cmd_t cmd;
  logic    cmd_valid;
  logic    lsu_ex_flush_i;
  logic    lsu_ex_flush_o;
  elen_t   operand_o;
  logic    operand_valid_o;
  logic    operand_ready_i;
  logic    cmd_pop_o;

  integer      seed;
  logic [31:0] rnd;
  int          cyc;
  int          ret_due;
  int          last_ret;
  int          credit;
  int          cmd_pend;
  int          ready_mode;
  logic        flush_prev;
  elen_t       pend_q[$];
  elen_t       ret_w[$];
  int          ret_t[$];
  elen_t       exp_q[$];
  bit          exp_pop_q[$];
  bit          exp_last_q[$];

  operand_queue_top uut (
    .clk_i                    (clk_i                ),
    .rst_n_i                  (rst_n_i              ),
    .operand_i                (operand_i            ),
    .operand_valid_i          (operand_valid_i      ),
    .operand_issued_i         (operand_issued_i     ),
    .operand_queue_ready_o    (operand_queue_ready_o),
    .operand_queue_cmd_i      (cmd                  ),
    .operand_queue_cmd_valid_i(cmd_valid            ),
    .lsu_ex_flush_i           (lsu_ex_flush_i       ),
    .lsu_ex_flush_o           (lsu_ex_flush_o       ),
    .operand_o                (operand_o            ),
    .operand_valid_o          (operand_valid_o      ),
    .operand_ready_i          (operand_ready_i      ),
    .cmd_pop_o                (cmd_pop_o            )
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Expected output k (0 low half, 1 high half) built from input word w
  function automatic elen_t ref_format(oq_cmd_t c, elen_t w, int k);
    elen_t res;
    elen_t e;
    elen_t mask;
    int    ew;
    res = '0;
    if (c.conv == CONV_NONE) begin
      return w;
    end
    ew   = 8 << int'(c.eew);
    mask = (64'd1 << ew) - 1;
    for (int i = 0; i < 32 / ew; i++) begin
      e = (w >> (32 * k + ew * i)) & mask;
      if (c.conv == CONV_SEXT2 && e[ew-1]) begin
        e = e | ~mask;
      end
      res = res | ((e & ((64'd1 << (2 * ew)) - 1)) << (2 * ew * i));
    end
    return res;
  endfunction

  task automatic check_value(logic [63:0] got, logic [63:0] exp, string what);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("tests failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // Strobes one command and queues its input words and expected outputs
  task automatic send_cmd(conv_e conv, eew_e eew, int n);
    oq_cmd_t c;
    elen_t   w;
    c.conv   = conv;
    c.eew    = eew;
    c.nwords = `OQ_VL_W'(n);
    w        = '0;
    while (cmd_pend >= `OQ_CMD_DEPTH) @(posedge clk_i);
    @(posedge clk_i);
    #1;
    cmd       = c;
    cmd_valid = 1'b1;
    cmd_pend  = cmd_pend + 1;
    @(posedge clk_i);
    #1;
    cmd_valid = 1'b0;
    for (int k = 0; k < n; k++) begin
      if (conv == CONV_NONE || k % 2 == 0) begin
        w = {$random(seed), $random(seed)};
        // Top element negative at every eew
        if (conv == CONV_SEXT2) begin
          w[`OQ_ELEN-1] = 1'b1;
        end
        pend_q.push_back(w);
      end
      exp_q.push_back(ref_format(c, w, (conv == CONV_NONE) ? 0 : k % 2));
      exp_pop_q.push_back(conv == CONV_NONE || k % 2 == 1 || k == n - 1);
      exp_last_q.push_back(k == n - 1);
    end
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0 || pend_q.size() != 0) @(posedge clk_i);
    repeat (2) @(posedge clk_i);
  endtask

  //////////////////////////////
  // Requester and FU ready
  //////////////////////////////

  always @(posedge clk_i) begin
    #1;
    cyc              = cyc + 1;
    operand_valid_i  = 1'b0;
    operand_issued_i = 1'b0;
    if (ret_t.size() != 0 && ret_t[0] <= cyc) begin
      operand_valid_i = 1'b1;
      operand_i       = ret_w.pop_front();
      ret_t.delete(0);
    end
    if (rst_n_i && operand_queue_ready_o && pend_q.size() != 0) begin
      operand_issued_i = 1'b1;
      rnd              = $random(seed);
      ret_due          = cyc + 1 + int'(rnd % 32'd3);
      // Register file answers in issue order
      if (ret_due <= last_ret) begin
        ret_due = last_ret + 1;
      end
      last_ret = ret_due;
      ret_w.push_back(pend_q.pop_front());
      ret_t.push_back(ret_due);
    end
    rnd = $random(seed);
    case (ready_mode)
      0:       operand_ready_i = 1'b1;
      1:       operand_ready_i = rnd[0];
      default: operand_ready_i = 1'b0;
    endcase
  end

  //////////////////////////////
  // Compare and credit model
  //////////////////////////////

  always @(negedge clk_i) begin
    if (rst_n_i) begin
      check_value(lsu_ex_flush_o, flush_prev, "lsu_ex_flush_o");
      check_value(operand_queue_ready_o, credit < `OQ_DATA_DEPTH, "operand_queue_ready_o");
      if (operand_valid_o && operand_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("Output word at %0t ns with no expected word left", $time);
          $display("tests failed");
          $fatal(1, "unexpected output");
        end
        check_value(operand_o, exp_q.pop_front(), "operand_o");
        check_value(cmd_pop_o, exp_last_q.pop_front(), "cmd_pop_o");
        if (exp_pop_q.pop_front()) begin
          credit = credit - 1;
        end
        if (cmd_pop_o) begin
          cmd_pend = cmd_pend - 1;
        end
      end else begin
        check_value(cmd_pop_o, 1'b0, "cmd_pop_o without transfer");
      end
      if (operand_issued_i) begin
        credit = credit + 1;
      end
      if (lsu_ex_flush_o) begin
        credit = 0;
      end
    end
    flush_prev = lsu_ex_flush_i;
  end

  initial begin
    #(TOTAL_WORDS * 20 * CLK_PERIOD);
    $display("Timeout: the queue stopped producing output before all tests ended");
    $display("tests failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    seed             = 32'ha434;
    cyc              = 0;
    last_ret         = 0;
    credit           = 0;
    cmd_pend         = 0;
    ready_mode       = 0;
    flush_prev       = 1'b0;
    rst_n_i          = 1'b0;
    operand_i        = '0;
    operand_valid_i  = 1'b0;
    operand_issued_i = 1'b0;
    cmd              = '0;
    cmd_valid        = 1'b0;
    lsu_ex_flush_i   = 1'b0;
    operand_ready_i  = 1'b0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    // Pass-through
    send_cmd(CONV_NONE, EW8, 1);
    send_cmd(CONV_NONE, EW8, 4);
    send_cmd(CONV_NONE, EW8, 7);
    wait_drain();
    // Signed extension
    send_cmd(CONV_SEXT2, EW8, 4);
    send_cmd(CONV_SEXT2, EW16, 6);
    send_cmd(CONV_SEXT2, EW32, 2);
    wait_drain();
    // Odd unsigned count, next command starts on a fresh word
    send_cmd(CONV_ZEXT2, EW16, 5);
    send_cmd(CONV_NONE, EW8, 2);
    send_cmd(CONV_ZEXT2, EW8, 3);
    wait_drain();
    // Random back-pressure
    ready_mode = 1;
    send_cmd(CONV_NONE, EW8, 8);
    send_cmd(CONV_SEXT2, EW8, 7);
    send_cmd(CONV_ZEXT2, EW32, 6);
    wait_drain();
    @(negedge clk_i);
    check_value(operand_queue_ready_o, 1'b1, "operand_queue_ready_o after drain");

    //////////////////////////////
    // Flush with words parked
    //////////////////////////////
    // A full FIFO of stalled words drops ready
    ready_mode = 2;
    send_cmd(CONV_NONE, EW8, `OQ_DATA_DEPTH);
    while (pend_q.size() != 0 || ret_t.size() != 0) @(posedge clk_i);
    repeat (2) @(posedge clk_i);
    #1;
    lsu_ex_flush_i = 1'b1;
    @(posedge clk_i);
    #1;
    lsu_ex_flush_i = 1'b0;
    @(posedge clk_i);
    #1;
    exp_q.delete();
    exp_pop_q.delete();
    exp_last_q.delete();
    cmd_pend   = 0;
    ready_mode = 1;
    repeat (4) begin
      @(negedge clk_i);
      check_value(operand_valid_o, 1'b0, "operand_valid_o after flush");
      check_value(operand_queue_ready_o, 1'b1, "operand_queue_ready_o after flush");
    end
    send_cmd(CONV_SEXT2, EW16, 4);
    wait_drain();

    @(negedge clk_i);
    if (pend_q.size() != 0 || cmd_pend != 0 || !operand_queue_ready_o) begin
      $display("Run ended with words or commands still pending");
      $display("tests failed");
      $fatal(1, "work left over");
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: operand_queue_top.sv
//////////////////////////////
// Operand queue top
// Intake, data FIFO and formatter of one lane queue
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "oq_cfg.svh"

module operand_queue_top import oq_data_pkg::*; import oq_cmd_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  // Register file and requester
  input  elen_t   operand_i,
  input  logic    operand_valid_i,
  input  logic    operand_issued_i,
  output logic    operand_queue_ready_o,
  input  oq_cmd_t operand_queue_cmd_i,
  input  logic    operand_queue_cmd_valid_i,
  // Store exception flush
  input  logic    lsu_ex_flush_i,
  output logic    lsu_ex_flush_o,
  // Functional unit
  output elen_t   operand_o,
  output logic    operand_valid_o,
  input  logic    operand_ready_i,
  output logic    cmd_pop_o
);

  logic  push;
  elen_t push_data;
  logic  pop;
  logic  empty;
  elen_t head;

  oq_operand_intake i_intake (
    .clk_i                (clk_i                ),
    .rst_n_i              (rst_n_i              ),
    .operand_i            (operand_i            ),
    .operand_valid_i      (operand_valid_i      ),
    .operand_issued_i     (operand_issued_i     ),
    .operand_queue_ready_o(operand_queue_ready_o),
    .pop_i                (pop                  ),
    .lsu_ex_flush_i       (lsu_ex_flush_i       ),
    .push_o               (push                 ),
    .push_data_o          (push_data            ),
    .flush_o              (lsu_ex_flush_o       )
  );

  oq_data_fifo i_data_fifo (
    .clk_i      (clk_i         ),
    .rst_n_i    (rst_n_i       ),
    .flush_i    (lsu_ex_flush_o),
    .push_i     (push          ),
    .push_data_i(push_data     ),
    .pop_i      (pop           ),
    .empty_o    (empty         ),
    .head_o     (head          )
  );

  oq_operand_formatter i_formatter (
    .clk_i          (clk_i                    ),
    .rst_n_i        (rst_n_i                  ),
    .flush_i        (lsu_ex_flush_o           ),
    .cmd_i          (operand_queue_cmd_i      ),
    .cmd_valid_i    (operand_queue_cmd_valid_i),
    .empty_i        (empty                    ),
    .head_i         (head                     ),
    .operand_ready_i(operand_ready_i          ),
    .pop_o          (pop                      ),
    .operand_o      (operand_o                ),
    .operand_valid_o(operand_valid_o          ),
    .cmd_pop_o      (cmd_pop_o                )
  );

endmodule

`default_nettype wire

// File: oq_operand_formatter.sv
//////////////////////////////
// Operand formatter
// Command buffer and output formatting toward the
// functional unit, with pass-through and 2x extension
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "oq_cfg.svh"

module oq_operand_formatter import oq_data_pkg::*; import oq_cmd_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    flush_i,
  input  oq_cmd_t cmd_i,
  input  logic    cmd_valid_i,
  input  logic    empty_i,
  input  elen_t   head_i,
  input  logic    operand_ready_i,
  output logic    pop_o,
  output elen_t   operand_o,
  output logic    operand_valid_o,
  output logic    cmd_pop_o
);

  oq_cmd_t                           cmd_buf_q [`OQ_CMD_DEPTH];
  logic [$clog2(`OQ_CMD_DEPTH)-1:0] cmd_wr_ptr_q;
  logic [$clog2(`OQ_CMD_DEPTH)-1:0] cmd_rd_ptr_q;
  logic [`OQ_CNT_W-1:0]             cmd_cnt_q;
  oq_cmd_t                          cmd_head;
  fmt_state_e                       state_q;
  fmt_state_e                       state_d;
  logic [`OQ_VL_W-1:0]              remaining_q;
  logic [`OQ_ELEN/2-1:0]            half;
  logic                             fire;
  logic                             last_word;

  // Doubles every element of one half word
  function automatic elen_t extend2(logic [`OQ_ELEN/2-1:0] src, eew_e eew, logic sgn);
    elen_t res;
    res = '0;
    case (eew)
      EW8: begin
        for (int i = 0; i < 4; i++) begin
          res[16*i +: 16] = {{8{sgn & src[8*i+7]}}, src[8*i +: 8]};
        end
      end
      EW16: begin
        for (int i = 0; i < 2; i++) begin
          res[32*i +: 32] = {{16{sgn & src[16*i+15]}}, src[16*i +: 16]};
        end
      end
      default: res = {{32{sgn & src[31]}}, src};
    endcase
    return res;
  endfunction

  assign cmd_head        = cmd_buf_q[cmd_rd_ptr_q];
  assign operand_valid_o = (state_q != FMT_IDLE) && !empty_i;
  assign fire            = operand_valid_o && operand_ready_i;
  assign last_word       = (remaining_q == `OQ_VL_W'(1));
  assign cmd_pop_o       = fire && last_word;
  assign half = (state_q == FMT_HI) ? head_i[`OQ_ELEN-1:`OQ_ELEN/2] : head_i[`OQ_ELEN/2-1:0];

  always_comb begin
    case (cmd_head.conv)
      CONV_SEXT2: operand_o = extend2(half, cmd_head.eew, 1'b1);
      CONV_ZEXT2: operand_o = extend2(half, cmd_head.eew, 1'b0);
      default:    operand_o = head_i;
    endcase
  end

  //////////////////////////////
  // Formatter FSM
  //////////////////////////////

  always_comb begin
    pop_o   = 1'b0;
    state_d = state_q;
    case (state_q)
      FMT_IDLE: begin
        if (cmd_cnt_q != '0) state_d = FMT_LO;
      end
      FMT_LO: begin
        if (fire) begin
          if (cmd_head.conv == CONV_NONE) begin
            pop_o = 1'b1;
          end else begin
            // Odd count ends here and drops the upper half
            pop_o   = last_word;
            state_d = FMT_HI;
          end
          if (last_word) state_d = FMT_IDLE;
        end
      end
      FMT_HI: begin
        if (fire) begin
          pop_o   = 1'b1;
          state_d = last_word ? FMT_IDLE : FMT_LO;
        end
      end
      default: state_d = FMT_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (cmd_valid_i) begin
      cmd_buf_q[cmd_wr_ptr_q] <= cmd_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q      <= FMT_IDLE;
      remaining_q  <= '0;
      cmd_wr_ptr_q <= '0;
      cmd_rd_ptr_q <= '0;
      cmd_cnt_q    <= '0;
    end else if (flush_i) begin
      state_q      <= FMT_IDLE;
      remaining_q  <= '0;
      cmd_wr_ptr_q <= '0;
      cmd_rd_ptr_q <= '0;
      cmd_cnt_q    <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == FMT_IDLE && state_d == FMT_LO) begin
        remaining_q <= cmd_head.nwords;
      end else if (fire) begin
        remaining_q <= remaining_q - 1'b1;
      end
      if (cmd_valid_i) begin
        cmd_wr_ptr_q <= (int'(cmd_wr_ptr_q) == `OQ_CMD_DEPTH - 1) ? '0 : cmd_wr_ptr_q + 1'b1;
      end
      if (cmd_pop_o) begin
        cmd_rd_ptr_q <= (int'(cmd_rd_ptr_q) == `OQ_CMD_DEPTH - 1) ? '0 : cmd_rd_ptr_q + 1'b1;
      end
      case ({cmd_valid_i, cmd_pop_o})
        2'b10:   cmd_cnt_q <= cmd_cnt_q + 1'b1;
        2'b01:   cmd_cnt_q <= cmd_cnt_q - 1'b1;
        default: cmd_cnt_q <= cmd_cnt_q;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: oq_data_fifo.sv
//////////////////////////////
// Operand data FIFO
// Circular buffer of operand words with head lookahead
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "oq_cfg.svh"

module oq_data_fifo import oq_data_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  flush_i,
  input  logic  push_i,
  input  elen_t push_data_i,
  input  logic  pop_i,
  output logic  empty_o,
  output elen_t head_o
);

  elen_t                              mem_q [`OQ_DATA_DEPTH];
  logic [$clog2(`OQ_DATA_DEPTH)-1:0] wr_ptr_q;
  logic [$clog2(`OQ_DATA_DEPTH)-1:0] rd_ptr_q;
  logic [`OQ_CNT_W-1:0]              fill_q;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (int'(wr_ptr_q) == `OQ_DATA_DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (int'(rd_ptr_q) == `OQ_DATA_DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   fill_q <= fill_q + 1'b1;
        2'b01:   fill_q <= fill_q - 1'b1;
        default: fill_q <= fill_q;
      endcase
    end
  end

  assign empty_o = (fill_q == '0);
  assign head_o  = mem_q[rd_ptr_q];

endmodule

`default_nettype wire

// File: oq_operand_intake.sv
//////////////////////////////
// Operand intake
// Registers incoming operands and the store flush,
// tracks credits of issued operands
//////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "oq_cfg.svh"

module oq_operand_intake import oq_data_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  // From the register file
  input  elen_t operand_i,
  input  logic  operand_valid_i,
  // Requester side
  input  logic  operand_issued_i,
  output logic  operand_queue_ready_o,
  // Consumed word from the formatter
  input  logic  pop_i,
  input  logic  lsu_ex_flush_i,
  // Toward FIFO and formatter
  output logic  push_o,
  output elen_t push_data_o,
  output logic  flush_o
);

  logic [`OQ_CNT_W-1:0] credit_cnt_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      push_o  <= 1'b0;
      flush_o <= 1'b0;
    end else begin
      push_o  <= operand_valid_i;
      flush_o <= lsu_ex_flush_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (operand_valid_i) begin
      push_data_o <= operand_i;
    end
  end

  // Words issued but not yet consumed
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credit_cnt_q <= '0;
    end else if (flush_o) begin
      credit_cnt_q <= '0;
    end else begin
      case ({operand_issued_i, pop_i})
        2'b10:   credit_cnt_q <= credit_cnt_q + 1'b1;
        2'b01:   credit_cnt_q <= credit_cnt_q - 1'b1;
        default: credit_cnt_q <= credit_cnt_q;
      endcase
    end
  end

  assign operand_queue_ready_o = (credit_cnt_q < `OQ_DATA_DEPTH);

endmodule

`default_nettype wire

// File: oq_cmd_pkg.sv
//////////////////////////////
// Operand queue command types
// Conversion opcode, formatter FSM states, command word
//////////////////////////////

`default_nettype none

`include "oq_cfg.svh"

package oq_cmd_pkg;

  import oq_data_pkg::*;

  typedef enum logic [1:0] {
    CONV_NONE  = 2'd0,
    CONV_SEXT2 = 2'd1,
    CONV_ZEXT2 = 2'd2
  } conv_e;

  typedef enum logic [1:0] {
    FMT_IDLE = 2'd0,
    FMT_LO   = 2'd1,
    FMT_HI   = 2'd2
  } fmt_state_e;

  // nwords counts output words, not input words
  typedef struct packed {
    conv_e               conv;
    eew_e                eew;
    logic [`OQ_VL_W-1:0] nwords;
  } oq_cmd_t;

endpackage

`default_nettype wire

// File: oq_data_pkg.sv
//////////////////////////////
// Operand data types
// Operand word and source element width
//////////////////////////////

`default_nettype none

`include "oq_cfg.svh"

package oq_data_pkg;

  typedef logic [`OQ_ELEN-1:0] elen_t;

  // Source element width for extension
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2
  } eew_e;

endpackage

`default_nettype wire

// File: oq_cfg.svh
//////////////////////////////
// Operand queue configuration
// Widths and depths shared by the RTL and the testbench
//////////////////////////////

`ifndef OQ_CFG_SVH
`define OQ_CFG_SVH

// Operand word width in bits
`define OQ_ELEN 64

// Buffer depths
`define OQ_DATA_DEPTH 4
`define OQ_CMD_DEPTH 2

// Occupancy and credit counters
`define OQ_CNT_W 3
`define OQ_VL_W 8

`endif
